// File: project.f
hdl/patch_pkg.sv
hdl/patch_sram_bank.sv
hdl/pixel_packer.sv
hdl/query_patch_mem.sv
hdl/patch_sad_unit.sv
hdl/patch_match_top.sv
sim/patch_checker.sv
sim/tb_patch_match.sv

// File: Bender.yml
package:
  name: patch_match

sources:
  - hdl/patch_pkg.sv
  - hdl/patch_sram_bank.sv
  - hdl/pixel_packer.sv
  - hdl/query_patch_mem.sv
  - hdl/patch_sad_unit.sv
  - hdl/patch_match_top.sv
  - target: test
    files:
      - sim/patch_checker.sv
      - sim/tb_patch_match.sv

// File: sim/tb_patch_match.sv
`timescale 1ns/1ps
// patch match testbench streaming pixels through free run, random gap and stall phases
module tb_patch_match;
  import patch_pkg::*;

  localparam int ADDR_WIDTH = 9;
  localparam int SHORT_PATCHES = 20;
  localparam int LONG_PATCHES = 600;
  localparam int STALL_WAIT = 40;  // cycles of pix_ready low that count as a full stall
  // two long phases of five pixel patches doubled for gaps plus stall time and margin
  localparam int TIMEOUT_CYCLES = 2 * LONG_PATCHES * PATCH_SIZE * 2 + 8000;

  logic                   clk;
  logic                   rst;
  logic [PIX_WIDTH-1:0]   pix_data;
  logic                   pix_valid;
  logic                   pix_ready;
  patch_word_u            template_pix;
  logic [SCORE_WIDTH-1:0] score;
  logic                   score_valid;
  logic                   score_ready;

  int   seed;
  int   ready_mode;  // 0 always ready, 1 random, 2 held low
  int   sent_patches;
  int   phase_base;
  int   stall_patches;
  logic stall_seen;
  int   tb_errors;
  int   checker_errors;
  int   score_count;
  int   cycles;

  patch_match_top #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) dut (
    .clk          (clk),
    .rst          (rst),
    .pix_data     (pix_data),
    .pix_valid    (pix_valid),
    .pix_ready    (pix_ready),
    .template_pix (template_pix),
    .score        (score),
    .score_valid  (score_valid),
    .score_ready  (score_ready)
  );

  patch_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .pix_data     (pix_data),
    .pix_valid    (pix_valid),
    .pix_ready    (pix_ready),
    .template_pix (template_pix),
    .score        (score),
    .score_valid  (score_valid),
    .score_ready  (score_ready),
    .error_count  (checker_errors),
    .score_count  (score_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // one clock with inputs changing 1 ns after the edge
  task step();
    @(posedge clk);
    #1;
    case (ready_mode)
      0:       score_ready = 1'b1;
      1:       score_ready = 1'($random(seed));
      default: score_ready = 1'b0;
    endcase
  endtask

  task send_pixel(input logic gaps);
    logic taken;
    int   wait_cycles;
    taken = 1'b0;
    wait_cycles = 0;
    if (gaps) begin
      while (($random(seed) & 3) == 0) begin
        pix_valid = 1'b0;
        step();
      end
    end
    pix_valid = 1'b1;
    pix_data  = PIX_WIDTH'($random(seed));
    while (!taken) begin
      @(negedge clk);
      taken = pix_ready;
      if (!taken) begin
        wait_cycles++;
        if (ready_mode == 2 && wait_cycles == STALL_WAIT) begin
          stall_seen    = 1'b1;
          stall_patches = sent_patches - phase_base;
          ready_mode    = 1;  // release the back-pressure
        end
      end
      step();
    end
  endtask

  task send_patch(input logic gaps);
    repeat (PATCH_SIZE) send_pixel(gaps);
    sent_patches++;
  endtask

  // template only changes here while the pipeline is drained
  task run_phase(input int n, input logic gaps, input int mode);
    template_pix.raw = PATCH_WIDTH'({$random(seed), $random(seed)});
    ready_mode = mode;
    phase_base = sent_patches;
    repeat (n) send_patch(gaps);
    pix_valid = 1'b0;
    if (ready_mode == 2) begin
      ready_mode = 1;
    end
    while (score_count < sent_patches) begin
      step();
    end
  endtask

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d of %0d scores seen", cycles, score_count,
             sent_patches);
    $display("errors %0d, scores %0d of %0d patches", tb_errors + checker_errors,
             score_count, sent_patches);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    seed          = 32'h06d4_14f3;
    rst           = 1'b1;
    pix_valid     = 1'b0;
    pix_data      = '0;
    score_ready   = 1'b0;
    template_pix  = '0;
    ready_mode    = 0;
    sent_patches  = 0;
    phase_base    = 0;
    stall_patches = 0;
    stall_seen    = 1'b0;
    tb_errors     = 0;
    repeat (4) step();
    rst = 1'b0;
    @(negedge clk);
    if (score_valid !== 1'b0) begin
      tb_errors++;
      $display("Fail score_valid after reset expected 0 got %h", score_valid);
    end
    if (pix_ready !== 1'b1) begin
      tb_errors++;
      $display("Fail pix_ready after reset expected 1 got %h", pix_ready);
    end
    step();
    run_phase(SHORT_PATCHES, 1'b0, 0);
    run_phase(LONG_PATCHES, 1'b1, 1);  // wraps the ring and crosses banks
    run_phase(LONG_PATCHES, 1'b0, 2);
    if (!stall_seen) begin
      tb_errors++;
      $display("pix_ready never stayed low while score_ready was held low");
    end else if (stall_patches < (1 << dut.ADDR_WIDTH)) begin
      tb_errors++;
      $display("pix_ready dropped after only %0d patches, before storage was full",
               stall_patches);
    end
    repeat (20) step();
    if (score_count != sent_patches) begin
      tb_errors++;
      $display("%0d scores delivered for %0d patches sent", score_count, sent_patches);
    end
    $display("errors %0d, scores %0d of %0d patches", tb_errors + checker_errors,
             score_count, sent_patches);
    if (tb_errors + checker_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: sim/patch_checker.sv
`timescale 1ns/1ps
// score checker that rebuilds patches from pixels and compares each score with a reference sad
module patch_checker (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [patch_pkg::PIX_WIDTH-1:0]   pix_data,
  input  logic                              pix_valid,
  input  logic                              pix_ready,
  input  patch_pkg::patch_word_u            template_pix,
  input  logic [patch_pkg::SCORE_WIDTH-1:0] score,
  input  logic                              score_valid,
  input  logic                              score_ready,
  output int                                error_count,
  output int                                score_count
);
  import patch_pkg::*;

  logic [PATCH_WIDTH-1:0] patch_bits;  // pixels gathered so far
  int                     pix_idx;
  int                     expected_q [$];
  int                     exp_score;
  logic                   held_valid;  // score offered but not taken last cycle
  logic [SCORE_WIDTH-1:0] held_score;

  // sum of absolute pixel differences with pixel 0 in the low bits
  function automatic int sad_ref(input logic [PATCH_WIDTH-1:0] patch,
                                 input logic [PATCH_WIDTH-1:0] tmpl);
    int sum;
    int a;
    int b;
    sum = 0;
    for (int i = 0; i < PATCH_SIZE; i++) begin
      a = int'(patch[i*PIX_WIDTH +: PIX_WIDTH]);
      b = int'(tmpl[i*PIX_WIDTH +: PIX_WIDTH]);
      sum += (a > b) ? a - b : b - a;
    end
    return sum;
  endfunction

  // sampled mid-cycle where every handshake input is stable
  always @(negedge clk) begin
    if (rst) begin
      patch_bits  = '0;
      pix_idx     = 0;
      error_count = 0;
      score_count = 0;
      held_valid  = 1'b0;
      held_score  = '0;
      expected_q.delete();
    end else begin
      if (pix_valid && pix_ready) begin
        patch_bits[pix_idx*PIX_WIDTH +: PIX_WIDTH] = pix_data;
        if (pix_idx == PATCH_SIZE - 1) begin
          expected_q.push_back(sad_ref(patch_bits, template_pix.raw));
          pix_idx = 0;
        end else begin
          pix_idx++;
        end
      end
      if (held_valid) begin
        if (!score_valid) begin
          error_count++;
          $display("score_valid dropped before score_ready at %0t", $time);
        end else if (score !== held_score) begin
          error_count++;
          $display("Fail score changed under back-pressure, expected %h got %h",
                   held_score, score);
        end
      end
      if (score_valid && score_ready) begin
        score_count++;  // every delivered score, wanted or not
        if (expected_q.size() == 0) begin
          error_count++;
          $display("score %h delivered with no patch pending at %0t", score, $time);
        end else begin
          exp_score = expected_q.pop_front();
          if (score !== SCORE_WIDTH'(exp_score)) begin
            error_count++;
            $display("Fail score expected %h got %h", SCORE_WIDTH'(exp_score), score);
          end
        end
      end
      held_valid = score_valid && !score_ready;
      held_score = score;
    end
  end

endmodule

// File: hdl/patch_match_top.sv
`timescale 1ns/1ps
// patch match top, connects the pixel packer, query patch memory and sad unit
module patch_match_top #(
  parameter int ADDR_WIDTH = 9
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [patch_pkg::PIX_WIDTH-1:0]   pix_data,
  input  logic                              pix_valid,
  output logic                              pix_ready,
  input  patch_pkg::patch_word_u            template_pix,
  output logic [patch_pkg::SCORE_WIDTH-1:0] score,
  output logic                              score_valid,
  input  logic                              score_ready
);
  import patch_pkg::*;

  logic        wr_en;
  patch_word_u wr_patch;
  logic        slot_free;
  logic        rd_valid;
  patch_word_u rd_patch;
  logic        sad_credit;

  pixel_packer #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_packer (
    .clk       (clk),
    .rst       (rst),
    .pix_data  (pix_data),
    .pix_valid (pix_valid),
    .pix_ready (pix_ready),
    .wr_en     (wr_en),
    .wr_patch  (wr_patch),
    .slot_free (slot_free)
  );

  query_patch_mem #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_mem (
    .clk        (clk),
    .rst        (rst),
    .wr_en      (wr_en),
    .wr_patch   (wr_patch),
    .slot_free  (slot_free),
    .rd_valid   (rd_valid),
    .rd_patch   (rd_patch),
    .sad_credit (sad_credit)
  );

  patch_sad_unit u_sad (
    .clk          (clk),
    .rst          (rst),
    .rd_valid     (rd_valid),
    .rd_patch     (rd_patch),
    .sad_credit   (sad_credit),
    .template_pix (template_pix),
    .score        (score),
    .score_valid  (score_valid),
    .score_ready  (score_ready)
  );

endmodule

// File: hdl/patch_sad_unit.sv
`timescale 1ns/1ps
// patch sad unit, queues stored patches and scores each one against the template
module patch_sad_unit (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              rd_valid,
  input  patch_pkg::patch_word_u            rd_patch,
  output logic                              sad_credit,
  input  patch_pkg::patch_word_u            template_pix,
  output logic [patch_pkg::SCORE_WIDTH-1:0] score,
  output logic                              score_valid,
  input  logic                              score_ready
);
  import patch_pkg::*;

  localparam int QIDX_WIDTH = $clog2(SAD_CREDITS);
  localparam int QCNT_WIDTH = $clog2(SAD_CREDITS + 1);
  localparam logic [QIDX_WIDTH-1:0] QLAST = QIDX_WIDTH'(SAD_CREDITS - 1);
  localparam logic [QCNT_WIDTH-1:0] QFULL = QCNT_WIDTH'(SAD_CREDITS);

  patch_word_u            q_mem [SAD_CREDITS];
  logic [QIDX_WIDTH-1:0]  q_wr_idx;
  logic [QIDX_WIDTH-1:0]  q_rd_idx;
  logic [QCNT_WIDTH-1:0]  q_count;
  logic                   q_empty;
  patch_word_u            head;
  logic                   head_valid;
  logic                   pop;
  logic                   q_push;
  logic                   q_pop;
  logic [SCORE_WIDTH-1:0] head_sad;

  assign q_empty = (q_count == '0);

  // empty queue passes the arriving patch straight through
  assign head       = q_empty ? rd_patch : q_mem[q_rd_idx];
  assign head_valid = !q_empty || rd_valid;

  assign pop        = head_valid && (!score_valid || score_ready);
  assign q_push     = rd_valid && !(q_empty && pop);
  assign q_pop      = pop && !q_empty;
  assign sad_credit = pop;  // entry leaves, memory may read again

  always_comb begin
    head_sad = '0;
    for (int i = 0; i < PATCH_SIZE; i++) begin
      if (head.pix[i] > template_pix.pix[i]) begin
        head_sad = head_sad + SCORE_WIDTH'(head.pix[i] - template_pix.pix[i]);
      end else begin
        head_sad = head_sad + SCORE_WIDTH'(template_pix.pix[i] - head.pix[i]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (q_push) begin
      q_mem[q_wr_idx] <= rd_patch;
    end
    if (pop) begin
      score <= head_sad;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      q_wr_idx    <= '0;
      q_rd_idx    <= '0;
      q_count     <= '0;
      score_valid <= 1'b0;
    end else begin
      if (q_push) begin
        q_wr_idx <= (q_wr_idx == QLAST) ? '0 : q_wr_idx + 1'b1;
      end
      if (q_pop) begin
        q_rd_idx <= (q_rd_idx == QLAST) ? '0 : q_rd_idx + 1'b1;
      end
      q_count <= q_count + QCNT_WIDTH'(q_push) - QCNT_WIDTH'(q_pop);
      if (pop) begin
        score_valid <= 1'b1;
      end else if (score_ready) begin
        score_valid <= 1'b0;
      end
    end
  end

  // memory credits guarantee room for every arriving patch
  assert property (@(posedge clk) disable iff (rst) rd_valid |-> q_count < QFULL)
    else $error("patch_sad_unit: patch arrived with queue full");

endmodule

// File: hdl/query_patch_mem.sv
`timescale 1ns/1ps
// query patch memory, a two-bank ring buffer of patch words with credit flow on both sides
module query_patch_mem #(
  parameter int ADDR_WIDTH = 9
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   wr_en,
  input  patch_pkg::patch_word_u wr_patch,
  output logic                   slot_free,
  output logic                   rd_valid,
  output patch_pkg::patch_word_u rd_patch,
  input  logic                   sad_credit
);
  import patch_pkg::*;

  localparam int CRED_WIDTH = $clog2(SAD_CREDITS + 1);

  // one extra bit tells full from empty
  logic [ADDR_WIDTH:0]    wr_ptr;
  logic [ADDR_WIDTH:0]    rd_ptr;
  logic [CRED_WIDTH-1:0]  credits;  // free consumer queue entries
  logic                   ring_empty;
  logic                   ring_full;
  logic                   rd_issue;
  logic                   wr_bank;
  logic                   rd_bank;
  logic [1:0]             bank_we;
  logic [1:0]             bank_re;
  logic [PATCH_WIDTH-1:0] bank_rdata [2];
  logic                   rd_issue_q;
  logic                   rd_sel_q;

  assign ring_empty = (wr_ptr == rd_ptr);
  assign ring_full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                      (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

  // read only with data present and a queue entry reserved downstream
  assign rd_issue  = !ring_empty && (credits != '0);
  assign slot_free = rd_issue;  // slot is committed once its read issues

  // top address bit picks the bank
  assign wr_bank = wr_ptr[ADDR_WIDTH-1];
  assign rd_bank = rd_ptr[ADDR_WIDTH-1];
  assign bank_we = {wr_en && wr_bank, wr_en && !wr_bank};
  assign bank_re = {rd_issue && rd_bank, rd_issue && !rd_bank};

  for (genvar b = 0; b < 2; b++) begin : g_bank
    patch_sram_bank #(
      .BANK_ADDR_WIDTH(ADDR_WIDTH - 1)
    ) u_bank (
      .clk   (clk),
      .we    (bank_we[b]),
      .waddr (wr_ptr[ADDR_WIDTH-2:0]),
      .wdata (wr_patch.raw),
      .re    (bank_re[b]),
      .raddr (rd_ptr[ADDR_WIDTH-2:0]),
      .rdata (bank_rdata[b])
    );
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_issue) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CRED_WIDTH'(SAD_CREDITS);
    end else begin
      case ({sad_credit, rd_issue})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // bank select travels with the read, not the write address
  always_ff @(posedge clk) begin
    if (rd_issue) begin
      rd_sel_q <= rd_bank;
    end
    if (rd_issue_q) begin
      rd_patch.raw <= bank_rdata[rd_sel_q];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_issue_q <= 1'b0;
      rd_valid   <= 1'b0;
    end else begin
      rd_issue_q <= rd_issue;    // bank cycle
      rd_valid   <= rd_issue_q;  // output register cycle
    end
  end

  // packer credits must keep writes off a full ring
  assert property (@(posedge clk) disable iff (rst) wr_en |-> !ring_full)
    else $error("query_patch_mem: write into full ring");

  assert property (@(posedge clk) disable iff (rst) credits <= SAD_CREDITS)
    else $error("query_patch_mem: consumer credits above queue depth");

endmodule

// File: hdl/pixel_packer.sv
`timescale 1ns/1ps
// pixel packer, gathers incoming pixels into patch words and writes them against storage credits
module pixel_packer #(
  parameter int ADDR_WIDTH = 9
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [patch_pkg::PIX_WIDTH-1:0] pix_data,
  input  logic                            pix_valid,
  output logic                            pix_ready,
  output logic                            wr_en,
  output patch_pkg::patch_word_u          wr_patch,
  input  logic                            slot_free
);
  import patch_pkg::*;

  localparam int IDX_WIDTH = $clog2(PATCH_SIZE);
  localparam logic [IDX_WIDTH-1:0] LAST_IDX = IDX_WIDTH'(PATCH_SIZE - 1);
  localparam logic [ADDR_WIDTH:0] DEPTH = {1'b1, {ADDR_WIDTH{1'b0}}};

  logic [IDX_WIDTH-1:0] pix_idx;
  logic [ADDR_WIDTH:0]  credits;  // free memory slots
  logic                 pix_accept;
  logic                 last_pix;
  patch_word_u          stage;

  assign last_pix = (pix_idx == LAST_IDX);

  // only the completing pixel waits for a credit
  assign pix_ready = !((credits == '0) && last_pix);
  assign pix_accept = pix_valid && pix_ready;

  // staging word doubles as write data, held through the wr_en cycle
  assign wr_patch = stage;

  always_ff @(posedge clk) begin
    if (pix_accept) begin
      stage.pix[pix_idx] <= pix_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pix_idx <= '0;
      wr_en   <= 1'b0;
    end else begin
      wr_en <= pix_accept && last_pix;  // write one cycle after the last pixel
      if (pix_accept) begin
        pix_idx <= last_pix ? '0 : pix_idx + 1'b1;
      end
    end
  end

  // credit return and spend can land in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= DEPTH;
    end else begin
      case ({slot_free, wr_en})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // memory must never hand back more slots than it has
  assert property (@(posedge clk) disable iff (rst) credits <= DEPTH)
    else $error("pixel_packer: storage credits above depth");

endmodule

// File: hdl/patch_sram_bank.sv
`timescale 1ns/1ps
// patch sram bank, behavioral 1-write 1-read synchronous memory with one cycle read latency
module patch_sram_bank #(
  parameter int BANK_ADDR_WIDTH = 8
) (
  input  logic                              clk,
  input  logic                              we,
  input  logic [BANK_ADDR_WIDTH-1:0]        waddr,
  input  logic [patch_pkg::PATCH_WIDTH-1:0] wdata,
  input  logic                              re,
  input  logic [BANK_ADDR_WIDTH-1:0]        raddr,
  output logic [patch_pkg::PATCH_WIDTH-1:0] rdata
);
  import patch_pkg::*;

  localparam int BANK_DEPTH = 2 ** BANK_ADDR_WIDTH;

  logic [PATCH_WIDTH-1:0] mem [0:BANK_DEPTH-1];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    if (re) begin
      rdata <= mem[raddr];  // old data on a same-address collision
    end
  end

endmodule

// File: hdl/patch_pkg.sv
// patch match package with pixel and patch constants and the patch word views
package patch_pkg;

  // pixel geometry, fixed here since the union below depends on it
  localparam int PIX_WIDTH = 11;
  localparam int PATCH_SIZE = 5;
  localparam int PATCH_WIDTH = PIX_WIDTH * PATCH_SIZE;

  // five differences of at most 2047 fit in 14 bits
  localparam int SCORE_WIDTH = 14;

  // consumer queue depth, also the memory's starting consumer credits
  localparam int SAD_CREDITS = 2;

  // one patch word seen two ways
  // raw is what the memory stores and moves
  // pix indexes single pixels, pixel 0 is the first to arrive (low bits)
  typedef union packed {
    logic [PATCH_WIDTH-1:0]               raw;
    logic [PATCH_SIZE-1:0][PIX_WIDTH-1:0] pix;
  } patch_word_u;

endpackage
